// ==== bench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ========================================
// Random numbers
// ========================================
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic msg_arg_t random_arg();
    logic [63:0] r;
    r[63:32] = lcg_next();
    r[31:0] = lcg_next();
    return r[55:0];
endfunction

// ========================================
// Serial port
// ========================================
// Ends on the edge that samples bit 0
task automatic send_msg(input msg_type_t msg_type, input msg_arg_t arg);
    logic [63:0] m;
    m = {msg_type, arg};
    for (int i = 63; i >= 0; i--) begin
        @(posedge sd_datInWrite_clk);
        sending <= 1'b1;
        data_in <= m[i];    // MSB first
    end
    @(posedge sd_datInWrite_clk);
    sending <= 1'b0;
    data_in <= 1'b0;
endtask

task automatic collect_resp(input string name, output resp_t resp);
    int wait_cnt;
    int bits;
    wait_cnt = 1;
    bits = 0;
    resp = '0;
    @(posedge sd_datInWrite_clk);
    while (!data_out_en && wait_cnt < resp_latency + 16) begin
        @(posedge sd_datInWrite_clk);
        wait_cnt++;
    end
    if (!data_out_en) begin
        $display("%s: no response appeared after the message", name);
        err_cnt++;
        return;
    end
    check_value({name, " latency"}, 64'(resp_latency), 64'(wait_cnt));
    while (data_out_en && bits < resp_len + 8) begin
        resp = {resp[62:0], data_out};
        bits++;
        @(posedge sd_datInWrite_clk);
    end
    check_value({name, " length"}, 64'(resp_len), 64'(bits));
endtask

// Covers the whole window where a response would sit
task automatic expect_silence(input string name);
    int seen;
    seen = 0;
    repeat (resp_latency + resp_len + 4) begin
        @(posedge sd_datInWrite_clk);
        if (data_out_en) seen++;
    end
    assert (seen == 0) else begin
        $display("%s: data_out_en went high although no response was expected", name);
        err_cnt++;
    end
endtask

// ========================================
// DatIn stream
// ========================================
task automatic stream_block(input int n_words, input access_mode_t avoid,
                            output datin_word_t word8);
    datin_word_t w;
    word8 = '0;
    @(posedge sd_datInWrite_clk);
    datin_rst <= 1'b1;
    @(posedge sd_datInWrite_clk);
    datin_rst <= 1'b0;
    for (int i = 0; i < n_words; i++) begin
        w = datin_word_t'(lcg_next() >> 8);
        if (i == 8) begin
            // New mode differs from the old one and from the reset value
            if (w[11:8] == avoid || w[11:8] == 4'h0) begin
                w[11:8] = (avoid == 4'hF) ? 4'h1 : avoid + 4'h1;
            end
            word8 = w;
        end
        datin_trigger <= 1'b1;
        datin_data <= w;
        @(posedge sd_datInWrite_clk);
    end
    datin_trigger <= 1'b0;
endtask

`endif

// ==== bench/tb_ice_ctrl.sv ====
`timescale 1ns/1ns

module tb_ice_ctrl;
    import cmd_pkg::*;

    localparam int turnaround_cycles = 8;
    localparam int resp_latency = turnaround_cycles + 1;    // Bit 0 sample to first bit seen
    localparam int cycle_limit = 6000;

    logic sd_datInWrite_clk = 1'b0;
    logic spi_rst_;
    logic data_in;
    logic data_out;
    logic data_out_en;
    led_t led;
    logic datin_rst;
    logic datin_trigger;
    datin_word_t datin_data;

    logic [31:0] lcg_state;
    logic sending;
    int err_cnt;
    int test_cnt;
    int pass_cnt;
    int test_err_start;
    int cycle_cnt;
    string cur_test;

    msg_arg_t arg;
    resp_t resp;
    led_t led_before;
    datin_word_t word8;
    access_mode_t mode;

    always #4 sd_datInWrite_clk = ~sd_datInWrite_clk;

    ice_ctrl_top #(
        .turnaround_cycles(turnaround_cycles)
    ) ice_ctrl_top_inst (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .data_in(data_in),
        .data_out(data_out),
        .data_out_en(data_out_en),
        .led(led),
        .datin_rst(datin_rst),
        .datin_trigger(datin_trigger),
        .datin_data(datin_data)
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start) begin
            pass_cnt++;
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, err_cnt - test_err_start);
        end
    endtask

    `include "tb_tasks.svh"

    // ========================================
    // Concurrent checks
    // ========================================
    a_reset_quiet: assert property (
        @(negedge sd_datInWrite_clk) !spi_rst_ |-> !data_out_en && !data_out && led == '0
    ) else begin
        $display("%s: outputs not cleared while reset is held", cur_test);
        err_cnt++;
    end

    // Host and response never overlap
    a_no_out_while_sending: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_) sending |-> !data_out_en
    ) else begin
        $display("%s: data_out_en high while a message is being sent", cur_test);
        err_cnt++;
    end

    always @(posedge sd_datInWrite_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        spi_rst_ = 1'b1;
        data_in = 1'b0;
        datin_rst = 1'b0;
        datin_trigger = 1'b0;
        datin_data = '0;
        sending = 1'b0;
        lcg_state = 32'd64327;
        err_cnt = 0;
        test_cnt = 0;
        pass_cnt = 0;
        cycle_cnt = 0;
        cur_test = "reset";
        @(posedge sd_datInWrite_clk);
        spi_rst_ <= 1'b0;
        repeat (5) @(posedge sd_datInWrite_clk);
        spi_rst_ <= 1'b1;
        repeat (2) @(posedge sd_datInWrite_clk);

        start_test("echo");
        for (int i = 0; i < 5; i++) begin
            arg = random_arg();
            send_msg(MSG_ECHO, arg);
            collect_resp($sformatf("echo %0d", i), resp);
            check_value($sformatf("echo %0d data", i), {8'h00, arg}, resp);
        end
        finish_test();

        start_test("led set");
        for (int i = 0; i < 2; i++) begin
            arg = random_arg();
            send_msg(MSG_LED_SET, arg);
            expect_silence($sformatf("led set %0d", i));
            check_value($sformatf("led set %0d value", i), 64'(arg[3:0]), 64'(led));
        end
        led_before = led;
        arg = random_arg();
        arg[3:0] = ~led_before;    // Would change led if decoded
        send_msg(8'h9F, arg);
        expect_silence("unknown type");
        check_value("unknown type led", 64'(led_before), 64'(led));
        finish_test();

        start_test("access mode capture");
        stream_block(32, 4'h0, word8);
        mode = word8[11:8];
        send_msg(MSG_DATIN_STATUS, random_arg());
        collect_resp("status after block", resp);
        check_value("status after block", {1'b1, 59'b0, mode}, resp);
        finish_test();

        start_test("acknowledge");
        send_msg(MSG_DATIN_ACK, random_arg());
        expect_silence("ack");
        send_msg(MSG_DATIN_STATUS, random_arg());
        collect_resp("status after ack", resp);
        check_value("status after ack", {1'b0, 59'b0, mode}, resp);
        stream_block(12, mode, word8);    // Cut short by the next datin_rst
        stream_block(32, word8[11:8], word8);
        mode = word8[11:8];
        send_msg(MSG_DATIN_STATUS, random_arg());
        collect_resp("status after restart", resp);
        check_value("status after restart", {1'b1, 59'b0, mode}, resp);
        finish_test();

        start_test("reset");
        arg = random_arg();
        arg[0] = 1'b1;
        send_msg(MSG_LED_SET, arg);
        expect_silence("led before reset");
        send_msg(MSG_ECHO, random_arg());
        repeat (resp_latency + 20) @(posedge sd_datInWrite_clk);
        check_value("response running", 64'(1), 64'(data_out_en));
        spi_rst_ <= 1'b0;
        repeat (5) @(posedge sd_datInWrite_clk);
        @(negedge sd_datInWrite_clk);
        check_value("reset data_out_en", 64'(0), 64'(data_out_en));
        check_value("reset led", 64'(0), 64'(led));
        @(posedge sd_datInWrite_clk);
        spi_rst_ <= 1'b1;
        repeat (2) @(posedge sd_datInWrite_clk);
        send_msg(MSG_DATIN_STATUS, random_arg());
        collect_resp("status after reset", resp);
        check_value("status after reset", 64'(0), resp);
        arg = random_arg();
        send_msg(MSG_ECHO, arg);
        collect_resp("echo after reset", resp);
        check_value("echo after reset", {8'h00, arg}, resp);
        finish_test();

        $display("Summary: %0d tests, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/cmd6_capture.sv ====
`timescale 1ns/1ns

module cmd6_capture (
    input logic sd_datInWrite_clk,
    input logic spi_rst_,
    input logic datin_rst,
    input logic datin_trigger,
    input cmd_pkg::datin_word_t datin_data,
    input logic done_clear,
    output cmd_pkg::access_mode_t access_mode,
    output logic block_done
);
    import cmd_pkg::*;

    word_cnt_t word_idx;
    logic block_full;    // Last word taken, waiting for datin_rst
    logic accept;
    logic last_word;

    assign accept = datin_trigger && !datin_rst && !block_full;
    assign last_word = (word_idx == word_cnt_t'(block_words - 1));

    // ========================================
    // Word index and capture
    // ========================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_idx <= '0;
            block_full <= 1'b0;
            access_mode <= '0;
        end else if (datin_rst) begin
            word_idx <= '0;          // New block, mode kept
            block_full <= 1'b0;
        end else if (accept) begin
            word_idx <= word_idx + 1'b1;
            if (last_word) block_full <= 1'b1;
            if (word_idx == word_cnt_t'(cmd6_word_idx)) begin
                access_mode <= datin_data[access_mode_lsb +: $bits(access_mode_t)];
            end
        end
    end

    // Sticky done, a finishing block wins over a clear
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            block_done <= 1'b0;
        end else if (accept && last_word) begin
            block_done <= 1'b1;
        end else if (done_clear) begin
            block_done <= 1'b0;
        end
    end

    a_no_word_past_block: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        block_full && !datin_rst |-> !datin_trigger
    );

endmodule

// ==== hdl/cmd_exec.sv ====
`timescale 1ns/1ns

module cmd_exec (
    input logic sd_datInWrite_clk,
    input logic spi_rst_,
    cmd_if.exec link,
    output cmd_pkg::led_t led,
    input cmd_pkg::access_mode_t access_mode,
    input logic block_done,
    output logic done_clear
);
    import cmd_pkg::*;

    logic is_echo;
    logic is_status;
    logic is_led_set;
    logic is_ack;
    resp_t resp_q;

    // ========================================
    // Decode on the strobe
    // ========================================
    assign is_echo = link.msg_strobe && (link.msg_type == MSG_ECHO);
    assign is_status = link.msg_strobe && (link.msg_type == MSG_DATIN_STATUS);
    assign is_led_set = link.msg_strobe && (link.msg_type == MSG_LED_SET);
    assign is_ack = link.msg_strobe && (link.msg_type == MSG_DATIN_ACK);

    // Other type codes fall through every decode above

    assign done_clear = is_ack;    // Clears the sticky flag next edge
    assign link.resp = resp_q;

    // LED register
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led <= '0;
        end else if (is_led_set) begin
            led <= link.msg_arg[$bits(led_t)-1:0];
        end
    end

    // Response word, only replaced by messages that answer
    always_ff @(posedge sd_datInWrite_clk) begin
        if (is_echo) begin
            resp_q <= echo_resp(link.msg_arg);
        end else if (is_status) begin
            resp_q <= status_resp(block_done, access_mode);
        end
    end

    // Clear pulse rides on one strobe and never stretches
    a_clear_on_strobe: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        done_clear |-> link.msg_strobe ##1 !done_clear
    );

endmodule

// ==== hdl/cmd_if.sv ====
`timescale 1ns/1ns

// Decoded message from the serial link, response back from the executor
interface cmd_if;
    import cmd_pkg::*;

    logic msg_strobe;       // One cycle, type and arg valid with it
    msg_type_t msg_type;
    msg_arg_t msg_arg;
    resp_t resp;            // Held from the edge after the strobe

    modport link (
        output msg_strobe,
        output msg_type,
        output msg_arg,
        input resp
    );

    modport exec (
        input msg_strobe,
        input msg_type,
        input msg_arg,
        output resp
    );

endinterface

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

    // ========================================
    // Message and response framing
    // ========================================
    localparam int msg_len = 64;
    localparam int resp_len = 64;
    localparam int msg_type_len = 8;
    localparam int msg_arg_len = msg_len - msg_type_len;
    localparam int msg_type_resp_bit = 6;    // Set when a response follows

    typedef logic [msg_len-1:0] msg_t;
    typedef logic [msg_type_len-1:0] msg_type_t;
    typedef logic [msg_arg_len-1:0] msg_arg_t;
    typedef logic [resp_len-1:0] resp_t;

    // Type codes, bit 7 doubles as the start bit
    localparam msg_type_t MSG_ECHO = 8'hC0;
    localparam msg_type_t MSG_DATIN_STATUS = 8'hC1;
    localparam msg_type_t MSG_LED_SET = 8'h80;
    localparam msg_type_t MSG_DATIN_ACK = 8'h81;

    typedef logic [3:0] led_t;

    // ========================================
    // DatIn block stream
    // ========================================
    typedef logic [15:0] datin_word_t;
    typedef logic [3:0] access_mode_t;

    localparam int block_words = 32;          // 512 bits of 16-bit words
    localparam int cmd6_word_idx = 8;         // Word holding the access-mode nibble
    localparam int access_mode_lsb = 8;
    typedef logic [$clog2(block_words)-1:0] word_cnt_t;

    // Status response fields
    localparam int resp_done_bit = 63;
    localparam int resp_mode_lsb = 0;

    function automatic resp_t echo_resp(msg_arg_t arg);
        return {{(resp_len - msg_arg_len){1'b0}}, arg};
    endfunction

    function automatic resp_t status_resp(logic done, access_mode_t mode);
        resp_t r;
        r = '0;
        r[resp_done_bit] = done;
        r[resp_mode_lsb +: $bits(access_mode_t)] = mode;
        return r;
    endfunction

endpackage

// ==== hdl/ice_ctrl_top.sv ====
`timescale 1ns/1ns

module ice_ctrl_top #(
    parameter int turnaround_cycles = 8
) (
    input logic sd_datInWrite_clk,
    input logic spi_rst_,

    // Serial command port
    input logic data_in,
    output logic data_out,
    output logic data_out_en,

    output cmd_pkg::led_t led,

    // DatIn word stream
    input logic datin_rst,
    input logic datin_trigger,
    input cmd_pkg::datin_word_t datin_data
);
    import cmd_pkg::*;

    access_mode_t access_mode;
    logic block_done;
    logic done_clear;

    cmd_if link_if ();

    // ========================================
    // Serial link
    // ========================================
    serial_link #(
        .turnaround_cycles(turnaround_cycles)
    ) serial_link_inst (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .data_in(data_in),
        .data_out(data_out),
        .data_out_en(data_out_en),
        .link(link_if.link)
    );

    // ========================================
    // Message execution
    // ========================================
    cmd_exec cmd_exec_inst (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .link(link_if.exec),
        .led(led),
        .access_mode(access_mode),
        .block_done(block_done),
        .done_clear(done_clear)
    );

    // CMD6 status block watcher
    cmd6_capture cmd6_capture_inst (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .datin_rst(datin_rst),
        .datin_trigger(datin_trigger),
        .datin_data(datin_data),
        .done_clear(done_clear),
        .access_mode(access_mode),
        .block_done(block_done)
    );

endmodule

// ==== hdl/serial_link.sv ====
`timescale 1ns/1ns

module serial_link #(
    parameter int turnaround_cycles = 8
) (
    input logic sd_datInWrite_clk,
    input logic spi_rst_,
    input logic data_in,
    output logic data_out,
    output logic data_out_en,
    cmd_if.link link
);
    import cmd_pkg::*;

    // Counter has to reach the longest of the three phases
    localparam int cnt_top = (msg_len - 2 > resp_len - 1) ? msg_len - 2 : resp_len - 1;
    localparam int cnt_max = (turnaround_cycles - 1 > cnt_top) ? turnaround_cycles - 1 : cnt_top;
    localparam int cnt_w = $clog2(cnt_max + 1);

    typedef enum logic [1:0] {
        idle,
        msg_in,
        turnaround,
        resp_out
    } link_state_t;

    link_state_t state;
    logic [cnt_w-1:0] cnt;
    logic strobe_q;
    msg_t msg_sr;
    resp_t resp_sr;

    assign link.msg_strobe = strobe_q;
    assign link.msg_type = msg_sr[msg_len-1 -: msg_type_len];
    assign link.msg_arg = msg_sr[msg_arg_len-1:0];

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state <= idle;
            cnt <= '0;
            strobe_q <= 1'b0;
            data_out <= 1'b0;
            data_out_en <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state)
                idle: begin
                    if (data_in) begin    // Start bit is msg bit 63
                        cnt <= cnt_w'(msg_len - 2);
                        state <= msg_in;
                    end
                end

                msg_in: begin
                    if (cnt == '0) begin
                        strobe_q <= 1'b1;
                        cnt <= cnt_w'(turnaround_cycles - 1);
                        state <= turnaround;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                turnaround: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (link.msg_type[msg_type_resp_bit]) begin
                        // First response bit goes out on this edge
                        data_out <= link.resp[resp_len-1];
                        data_out_en <= 1'b1;
                        cnt <= cnt_w'(resp_len - 1);
                        state <= resp_out;
                    end else begin
                        state <= idle;    // No answer expected
                    end
                end

                resp_out: begin
                    if (cnt == '0) begin
                        data_out <= 1'b0;
                        data_out_en <= 1'b0;
                        state <= idle;
                    end else begin
                        data_out <= resp_sr[resp_len-1];
                        cnt <= cnt - 1'b1;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // ========================================
    // Shift registers
    // ========================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if ((state == idle && data_in) || state == msg_in) begin
            msg_sr <= {msg_sr[msg_len-2:0], data_in};
        end

        if (state == turnaround && cnt == '0) begin
            resp_sr <= link.resp << 1;    // Bit 63 already on data_out
        end else if (state == resp_out) begin
            resp_sr <= resp_sr << 1;
        end
    end

    // Output only drives while a response is running
    a_out_en_in_resp: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        data_out_en |-> state == resp_out
    );

    a_strobe_single: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        link.msg_strobe |=> !link.msg_strobe
    );

endmodule

// ==== project.f ====
+incdir+bench
hdl/cmd_pkg.sv
hdl/cmd_if.sv
hdl/serial_link.sv
hdl/cmd_exec.sv
hdl/cmd6_capture.sv
hdl/ice_ctrl_top.sv
bench/tb_ice_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the serial command port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ice_ctrl -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
